// File: tests/hci_stim.txt
# name chan wr(1 write) addr data be mode(0 rr 1 prio 2 clear 3 rnd ready) prio exp gord rord
# gord and rord are the grant and response position inside the test, -1 skips that check
wr_rd      0 1 10 11111111 f 0 0 00000000 -1 -1
wr_rd      0 1 10 aabbccdd 5 0 0 00000000 -1 -1
wr_rd      0 0 10 00000000 0 0 0 11bb11dd -1 -1
wr_rd      1 1 11 22222222 f 0 0 00000000 -1 -1
wr_rd      1 1 11 01234567 a 0 0 00000000 -1 -1
wr_rd      1 0 11 00000000 0 0 0 01224522 -1 -1
wr_rd      2 1 20 33333333 f 0 0 00000000 -1 -1
wr_rd      2 1 20 deadbeef 3 0 0 00000000 -1 -1
wr_rd      2 0 20 00000000 0 0 0 3333beef -1 -1
wr_rd      3 1 21 44444444 f 0 0 00000000 -1 -1
wr_rd      3 1 21 cafef00d c 0 0 00000000 -1 -1
wr_rd      3 0 21 00000000 0 0 0 cafe4444 -1 -1
rr_all     0 0 10 00000000 0 0 0 11bb11dd 0 -1
rr_all     0 0 10 00000000 0 0 0 11bb11dd 4 -1
rr_all     1 0 11 00000000 0 0 0 01224522 1 -1
rr_all     1 0 11 00000000 0 0 0 01224522 5 -1
rr_all     2 0 20 00000000 0 0 0 3333beef 2 -1
rr_all     2 0 20 00000000 0 0 0 3333beef 6 -1
rr_all     3 0 21 00000000 0 0 0 cafe4444 3 -1
rr_all     3 0 21 00000000 0 0 0 cafe4444 7 -1
prio_force 0 0 10 00000000 0 1 1 11bb11dd 2 -1
prio_force 1 0 11 00000000 0 1 3 01224522 0 -1
prio_force 2 0 20 00000000 0 1 0 3333beef 3 -1
prio_force 3 0 21 00000000 0 1 2 cafe4444 1 -1
ooo        1 0 11 00000000 0 1 3 01224522 0 1
ooo        0 0 10 00000000 0 1 2 11bb11dd 1 0
ooo        3 0 21 00000000 0 1 1 cafe4444 2 3
ooo        2 0 20 00000000 0 1 0 3333beef 3 2
rnd_ready  0 1 30 55aa55aa f 3 0 00000000 -1 -1
rnd_ready  0 0 30 00000000 0 3 0 55aa55aa -1 -1
rnd_ready  1 1 31 0f0f0f0f f 3 0 00000000 -1 -1
rnd_ready  1 0 31 00000000 0 3 0 0f0f0f0f -1 -1
rnd_ready  2 1 40 12345678 f 3 0 00000000 -1 -1
rnd_ready  2 0 40 00000000 0 3 0 12345678 -1 -1
rnd_ready  3 1 41 87654321 f 3 0 00000000 -1 -1
rnd_ready  3 0 41 00000000 0 3 0 87654321 -1 -1
pre_clr    2 0 20 00000000 0 0 0 3333beef -1 -1
clr_rr     0 0 10 00000000 0 2 0 11bb11dd 0 -1
clr_rr     1 0 11 00000000 0 2 0 01224522 1 -1
clr_rr     2 0 20 00000000 0 2 0 3333beef 2 -1
clr_rr     3 0 21 00000000 0 2 0 cafe4444 3 -1

// File: files.f
+incdir+source
source/hci_pkg.sv
source/hci_mux_ooo.sv
source/hci_ooo_mem.sv
source/hci_ooo_top.sv
tests/tb_clk_gen.sv
tests/tb_hci_ooo.sv

// File: Bender.yml
package:
  name: hci_ooo

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/hci_pkg.sv
      - source/hci_mux_ooo.sv
      - source/hci_ooo_mem.sv
      - source/hci_ooo_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_hci_ooo.sv

// File: tests/tb_hci_ooo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the out-of-order mux and memory that replays the stimulus
// table test by test and checks grant order, response order and read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hci_params.svh"

module tb_hci_ooo;

  localparam int NCH      = `HCI_NB_CHAN;
  localparam int MAX_STIM = 64;

  // one table line where gord and rord of -1 mean not checked
  // mode 0 round-robin, 1 forced priority, 2 clear first, 3 random r_ready
  typedef struct packed {
    hci_pkg::id_t   chan;
    logic           write;
    hci_pkg::addr_t add;
    hci_pkg::data_t data;
    hci_pkg::be_t   be;
    logic [1:0]     mode;
    hci_pkg::prio_t prio;
    hci_pkg::data_t exp;
    int             gord;
    int             rord;
  } stim_t;

  logic                        clk;
  logic                        rst_n;
  logic                        clear;
  logic                        prio_force;
  hci_pkg::prio_t    [NCH-1:0] prio;
  logic              [NCH-1:0] req;
  hci_pkg::hci_req_t [NCH-1:0] req_data;
  logic              [NCH-1:0] gnt;
  logic              [NCH-1:0] r_valid;
  logic              [NCH-1:0] r_ready;
  hci_pkg::hci_rsp_t           rsp;

  stim_t stim      [MAX_STIM];
  string stim_name [MAX_STIM];
  int    n_stim;
  int    seed;
  int    errors;
  int    checks;
  int    n_tests;
  int    limit;
  int    cycles;

  // next line to issue, next line expected back and requests in flight
  int iss   [NCH];
  int ret   [NCH];
  int n_out [NCH];
  int n_gnt;
  int n_rsp;

  tb_clk_gen #(.PERIOD(4), .RST_CYCLES(3)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  hci_ooo_top i_dut (
    .clk_i            ( clk        ),
    .rst_ni           ( rst_n      ),
    .clear_i          ( clear      ),
    .priority_force_i ( prio_force ),
    .priority_i       ( prio       ),
    .in_req_i         ( req        ),
    .in_data_i        ( req_data   ),
    .in_gnt_o         ( gnt        ),
    .in_r_valid_o     ( r_valid    ),
    .in_r_ready_i     ( r_ready    ),
    .in_r_o           ( rsp        )
  );

  function automatic int next_line(input int c, input int from, input int last);
    int k;
    k = from;
    while (k <= last && int'(stim[k].chan) != c) begin
      k++;
    end
    return k;
  endfunction

  function automatic hci_pkg::hci_req_t make_req(input stim_t s);
    hci_pkg::hci_req_t r;
    r.add  = s.add;
    // wen high asks for a read
    r.wen  = ~s.write;
    r.data = s.data;
    r.be   = s.be;
    return r;
  endfunction

  task automatic load_stim();
    int          fd;
    int          rc;
    int          ch, wr, md, pr, go, ro;
    logic [31:0] ad, dt, bv, ex;
    string       text;
    string       nm;
    fd = $fopen("tests/hci_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tests/hci_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(text, fd);
        // skip comments and blank lines
        if (rc > 0 && text.len() > 1 && text[0] != "#") begin
          rc = $sscanf(text, "%s %d %d %h %h %h %d %d %h %d %d",
                       nm, ch, wr, ad, dt, bv, md, pr, ex, go, ro);
          if (rc == 11 && n_stim < MAX_STIM) begin
            stim_name[n_stim]  = nm;
            stim[n_stim].chan  = hci_pkg::id_t'(ch);
            stim[n_stim].write = wr[0];
            stim[n_stim].add   = hci_pkg::addr_t'(ad);
            stim[n_stim].data  = hci_pkg::data_t'(dt);
            stim[n_stim].be    = hci_pkg::be_t'(bv);
            stim[n_stim].mode  = md[1:0];
            stim[n_stim].prio  = hci_pkg::prio_t'(pr);
            stim[n_stim].exp   = hci_pkg::data_t'(ex);
            stim[n_stim].gord  = go;
            stim[n_stim].rord  = ro;
            n_stim++;
          end else begin
            $display("stimulus line could not be read: %s", text);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_stim == 0) begin
      $display("the stimulus file holds no test lines");
      errors++;
    end
  endtask

  task automatic take_gnt(input int c, input int last);
    if (stim[iss[c]].gord >= 0) begin
      checks++;
      assert (n_gnt == stim[iss[c]].gord) else begin
        $display("[ERROR] %s ch%0d grant position expected %0d actual %0d",
                 stim_name[iss[c]], c, stim[iss[c]].gord, n_gnt);
        errors++;
      end
    end
    n_gnt++;
    n_out[c]++;
    iss[c] = next_line(c, iss[c] + 1, last);
  endtask

  task automatic take_rsp(input int c, input int last);
    checks++;
    assert (n_out[c] > 0) begin
      assert (rsp.r_data === stim[ret[c]].exp) else begin
        $display("[ERROR] %s ch%0d read data expected %h actual %h",
                 stim_name[ret[c]], c, stim[ret[c]].exp, rsp.r_data);
        errors++;
      end
      // the id of a response is the index of the channel that asked
      assert (rsp.r_id === hci_pkg::id_t'(c)) else begin
        $display("[ERROR] %s ch%0d response id expected %0d actual %0d",
                 stim_name[ret[c]], c, c, rsp.r_id);
        errors++;
      end
      if (stim[ret[c]].rord >= 0) begin
        assert (n_rsp == stim[ret[c]].rord) else begin
          $display("[ERROR] %s ch%0d response position expected %0d actual %0d",
                   stim_name[ret[c]], c, stim[ret[c]].rord, n_rsp);
          errors++;
        end
      end
      n_out[c]--;
      ret[c] = next_line(c, ret[c] + 1, last);
    end else begin
      $display("channel %0d got a response with no request in flight", c);
      errors++;
    end
    n_rsp++;
  endtask

  task automatic run_test(input int first, input int last);
    int mode;
    int errs0;
    bit busy;
    mode  = int'(stim[first].mode);
    errs0 = errors;
    if (mode == 2) begin
      @(negedge clk);
      clear = 1'b1;
    end
    @(negedge clk);
    clear      = 1'b0;
    prio_force = (mode == 1);
    for (int k = first; k <= last; k++) begin
      prio[stim[k].chan] = stim[k].prio;
    end
    for (int c = 0; c < NCH; c++) begin
      iss[c]   = next_line(c, first, last);
      ret[c]   = iss[c];
      n_out[c] = 0;
    end
    n_gnt = 0;
    n_rsp = 0;
    busy  = 1'b1;
    while (busy) begin
      @(negedge clk);
      for (int c = 0; c < NCH; c++) begin
        req[c] = (iss[c] <= last);
        if (req[c]) begin
          req_data[c] = make_req(stim[iss[c]]);
        end
        // ready low about one cycle in four
        r_ready[c] = (mode == 3) ? (($random(seed) & 3) != 0) : 1'b1;
      end
      // outputs have settled and handshakes complete on the coming rising edge
      #1;
      busy = 1'b0;
      for (int c = 0; c < NCH; c++) begin
        if (r_valid[c] && r_ready[c]) begin
          take_rsp(c, last);
        end
        if (req[c] && gnt[c]) begin
          take_gnt(c, last);
        end
        if (iss[c] <= last || ret[c] <= last) begin
          busy = 1'b1;
        end
      end
    end
    @(negedge clk);
    req        = '0;
    r_ready    = '1;
    prio_force = 1'b0;
    // idle cycles also let the mux drop its held winner
    repeat (2) begin
      @(negedge clk);
      #1;
      checks++;
      assert (r_valid == '0) else begin
        $display("%s left a response behind after all were answered", stim_name[first]);
        errors++;
      end
    end
    n_tests++;
    $display("test %s %s with %0d requests and %0d errors", stim_name[first],
             (errors == errs0) ? "passed" : "failed", last - first + 1, errors - errs0);
  endtask

  initial begin : main
    int first;
    int last;
    seed       = 4;
    errors     = 0;
    checks     = 0;
    n_tests    = 0;
    n_stim     = 0;
    limit      = 0;
    clear      = 1'b0;
    prio_force = 1'b0;
    prio       = '0;
    req        = '0;
    req_data   = '0;
    r_ready    = '1;
    load_stim();
    limit = 20 * n_stim * `HCI_SLOW_LAT;
    @(posedge rst_n);
    repeat (2) @(negedge clk);
    // consecutive lines with the same name form one test
    first = 0;
    while (first < n_stim) begin
      last = first;
      while (last + 1 < n_stim && stim_name[last + 1] == stim_name[first]) begin
        last++;
      end
      run_test(first, last);
      first = last + 1;
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin : watchdog
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the tests did not finish within %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: tests/tb_clk_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock and active-low reset for the interconnect testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  // release on a falling edge, away from the edge the DUT samples on
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: source/hci_ooo_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// out-of-order mux in front of the two-bank memory, the testbench DUT
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hci_params.svh"

module hci_ooo_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    clear_i,
  input  logic                                    priority_force_i,
  input  hci_pkg::prio_t    [`HCI_NB_CHAN-1:0]    priority_i,

  // per-channel request and response
  input  logic              [`HCI_NB_CHAN-1:0]    in_req_i,
  input  hci_pkg::hci_req_t [`HCI_NB_CHAN-1:0]    in_data_i,
  output logic              [`HCI_NB_CHAN-1:0]    in_gnt_o,
  output logic              [`HCI_NB_CHAN-1:0]    in_r_valid_o,
  input  logic              [`HCI_NB_CHAN-1:0]    in_r_ready_i,
  output hci_pkg::hci_rsp_t                       in_r_o
);

  // single channel between mux and memory
  logic              mem_req;
  logic              mem_gnt;
  hci_pkg::hci_req_t mem_data;
  hci_pkg::id_t      mem_id;
  logic              mem_r_valid;
  logic              mem_r_ready;
  hci_pkg::hci_rsp_t mem_r;

  hci_mux_ooo #(
    .NB_CHAN ( `HCI_NB_CHAN )
  ) i_mux (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .clear_i          ( clear_i          ),
    .priority_force_i ( priority_force_i ),
    .priority_i       ( priority_i       ),
    .in_req_i         ( in_req_i         ),
    .in_data_i        ( in_data_i        ),
    .in_gnt_o         ( in_gnt_o         ),
    .in_r_valid_o     ( in_r_valid_o     ),
    .in_r_ready_i     ( in_r_ready_i     ),
    .in_r_o           ( in_r_o           ),
    .out_req_o        ( mem_req          ),
    .out_data_o       ( mem_data         ),
    .out_id_o         ( mem_id           ),
    .out_gnt_i        ( mem_gnt          ),
    .out_r_valid_i    ( mem_r_valid      ),
    .out_r_ready_o    ( mem_r_ready      ),
    .out_r_i          ( mem_r            )
  );

  // memory reflects mem_id back as r_id
  hci_ooo_mem i_mem (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .req_i     ( mem_req     ),
    .data_i    ( mem_data    ),
    .id_i      ( mem_id      ),
    .gnt_o     ( mem_gnt     ),
    .r_valid_o ( mem_r_valid ),
    .r_ready_i ( mem_r_ready ),
    .r_o       ( mem_r       )
  );

endmodule

// File: source/hci_ooo_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-bank memory model with a fast and a slow lane that reflects the
// request id into the response so the mux can return responses out of order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hci_params.svh"

module hci_ooo_mem (
  input  logic              clk_i,
  input  logic              rst_ni,

  // request channel
  input  logic              req_i,
  input  hci_pkg::hci_req_t data_i,
  input  hci_pkg::id_t      id_i,
  output logic              gnt_o,

  // response channel
  output logic              r_valid_o,
  input  logic              r_ready_i,
  output hci_pkg::hci_rsp_t r_o
);

  // words per bank with the banks interleaved on the address lsb
  localparam int unsigned BANK_WORDS = `HCI_DEPTH / 2;

  logic                           bank_sel;
  logic [$clog2(BANK_WORDS)-1:0]  bank_idx;
  logic                           out_sel;
  logic                           stall;
  logic [1:0]                     lane_done;
  logic [1:0]                     lane_pop;
  logic [1:0]                     lane_adv;
  logic [1:0]                     lane_accept;
  logic [1:0]                     lane_hs;
  hci_pkg::hci_rsp_t [1:0]        lane_rsp;

  assign bank_sel = data_i.add[0];
  assign bank_idx = data_i.add[`HCI_AW-1:1];

  // no grant while the target lane cannot take a new entry
  assign gnt_o = req_i & lane_accept[bank_sel];

  // slow lane wins when both have a finished response
  assign out_sel   = lane_done[1];
  assign r_valid_o = |lane_done;
  assign r_o       = lane_rsp[out_sel];

  // unaccepted output freezes both lanes
  assign stall = r_valid_o & ~r_ready_i;

  for (genvar b = 0; b < 2; b++) begin : gen_bank
    localparam int unsigned LAT = (b == 0) ? `HCI_FAST_LAT : `HCI_SLOW_LAT;
    // a one-cycle lane finishes right on entry
    localparam hci_pkg::lane_state_e ENTRY_STATE =
        (LAT == 1) ? hci_pkg::LANE_DONE : hci_pkg::LANE_BUSY;

    hci_pkg::data_t       bank_q  [BANK_WORDS];
    hci_pkg::lane_state_e state_q [LAT];
    hci_pkg::hci_rsp_t    slot_q  [LAT];
    hci_pkg::hci_rsp_t    entry_rsp;

    assign lane_hs[b] = req_i & gnt_o & (bank_sel == 1'(b));

    // last slot of the lane is the one offered to the output
    assign lane_done[b] = (state_q[LAT-1] == hci_pkg::LANE_DONE);
    assign lane_rsp[b]  = slot_q[LAT-1];
    assign lane_pop[b]  = r_valid_o & r_ready_i & (out_sel == 1'(b));

    // shift when the tail is empty or leaving this cycle
    assign lane_adv[b] = ~stall &
        ((state_q[LAT-1] == hci_pkg::LANE_IDLE) | lane_pop[b]);

    // a free head slot of a longer lane may fill even during a stall
    // since it cannot reach the output before the stall ends
    assign lane_accept[b] = lane_adv[b] |
        ((LAT > 1) && (state_q[0] == hci_pkg::LANE_IDLE));

    // read data is sampled at the handshake and writes answer zero
    always_comb begin
      entry_rsp.r_data = data_i.wen ? bank_q[bank_idx] : '0;
      entry_rsp.r_id   = id_i;
    end

    // byte-masked write into the bank
    always_ff @(posedge clk_i) begin : bank_write
      if (lane_hs[b] && !data_i.wen) begin
        for (int k = 0; k < `HCI_DW/8; k++) begin
          if (data_i.be[k]) begin
            bank_q[bank_idx][8*k +: 8] <= data_i.data[8*k +: 8];
          end
        end
      end
    end

    // slot states move down the lane and turn done in the tail slot
    always_ff @(posedge clk_i or negedge rst_ni) begin : lane_state
      if (!rst_ni) begin
        for (int k = 0; k < LAT; k++) begin
          state_q[k] <= hci_pkg::LANE_IDLE;
        end
      end else if (lane_adv[b]) begin
        for (int k = LAT - 1; k > 0; k--) begin
          if (state_q[k-1] == hci_pkg::LANE_IDLE) begin
            state_q[k] <= hci_pkg::LANE_IDLE;
          end else if (k == LAT - 1) begin
            state_q[k] <= hci_pkg::LANE_DONE;
          end else begin
            state_q[k] <= hci_pkg::LANE_BUSY;
          end
        end
        state_q[0] <= lane_hs[b] ? ENTRY_STATE : hci_pkg::LANE_IDLE;
      end else if (lane_hs[b]) begin
        state_q[0] <= ENTRY_STATE;
      end
    end

    // payload follows the states with id and data riding together
    always_ff @(posedge clk_i) begin : lane_payload
      if (lane_adv[b]) begin
        for (int k = LAT - 1; k > 0; k--) begin
          slot_q[k] <= slot_q[k-1];
        end
      end
      if (lane_hs[b]) begin
        slot_q[0] <= entry_rsp;
      end
    end
  end

  // response must hold while the initiator is not ready
  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o)
  ) else $error("response changed under back-pressure");

endmodule

// File: source/hci_mux_ooo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// N-to-1 request mux with round-robin or forced priority, tags each request
// with its channel id and routes responses back by id, out of order
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "hci_params.svh"

module hci_mux_ooo #(
  parameter int unsigned NB_CHAN = `HCI_NB_CHAN
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,

  input  logic                                 priority_force_i,
  input  hci_pkg::prio_t     [NB_CHAN-1:0]     priority_i,

  // initiator side
  input  logic               [NB_CHAN-1:0]     in_req_i,
  input  hci_pkg::hci_req_t  [NB_CHAN-1:0]     in_data_i,
  output logic               [NB_CHAN-1:0]     in_gnt_o,
  output logic               [NB_CHAN-1:0]     in_r_valid_o,
  input  logic               [NB_CHAN-1:0]     in_r_ready_i,
  output hci_pkg::hci_rsp_t                    in_r_o,

  // memory side
  output logic                                 out_req_o,
  output hci_pkg::hci_req_t                    out_data_o,
  output hci_pkg::id_t                         out_id_o,
  input  logic                                 out_gnt_i,
  input  logic                                 out_r_valid_i,
  output logic                                 out_r_ready_o,
  input  hci_pkg::hci_rsp_t                    out_r_i
);

  hci_pkg::id_t                  rr_counter_q;
  hci_pkg::id_t                  winner_d;
  hci_pkg::id_t                  winner_q;
  hci_pkg::prio_t [NB_CHAN-1:0]  eff_prio;
  logic                          out_hs;
  logic                          out_hs_q;
  logic                          any_req_q;

  assign out_hs = out_req_o & out_gnt_i;

  // round-robin pointer, one step per output handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin : rr_counter
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear_i) begin
      rr_counter_q <= '0;
    end else if (out_hs) begin
      if (rr_counter_q == hci_pkg::id_t'(NB_CHAN - 1)) begin
        rr_counter_q <= '0;
      end else begin
        rr_counter_q <= rr_counter_q + 1'b1;
      end
    end
  end

  // last winner plus the two flags that allow a new decision
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_regs
    if (!rst_ni) begin
      winner_q  <= '0;
      out_hs_q  <= 1'b0;
      any_req_q <= 1'b0;
    end else if (clear_i) begin
      winner_q  <= '0;
      out_hs_q  <= 1'b0;
      any_req_q <= 1'b0;
    end else begin
      winner_q  <= winner_d;
      out_hs_q  <= out_hs;
      any_req_q <= |in_req_i;
    end
  end

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    // round-robin rank: the channel under the pointer gets NB_CHAN-1,
    // the next one NB_CHAN-2 and so on around the ring
    assign eff_prio[ii] = priority_force_i ? priority_i[ii] :
        hci_pkg::prio_t'(NB_CHAN - 1 -
                         ((ii + NB_CHAN - int'(rr_counter_q)) % NB_CHAN));

    // grant only the current winner, and only if the memory takes it
    assign in_gnt_o[ii] = (winner_d == hci_pkg::id_t'(ii)) & in_req_i[ii] & out_gnt_i;

    // response goes to the channel whose id it carries
    assign in_r_valid_o[ii] = out_r_valid_i & (out_r_i.r_id == hci_pkg::id_t'(ii));
  end

  // winner-takes-all over the requesting channels
  always_comb begin : wta_comb
    logic           found;
    hci_pkg::prio_t best;
    found    = 1'b0;
    best     = '0;
    winner_d = winner_q;
    // decide again only after a handshake or an empty cycle
    // so a pending request cannot be overtaken
    if (out_hs_q || !any_req_q) begin
      winner_d = rr_counter_q;
      for (int k = 0; k < NB_CHAN; k++) begin
        // ties go to the lower channel index
        if (in_req_i[k] && (!found || eff_prio[k] > best)) begin
          found    = 1'b1;
          best     = eff_prio[k];
          winner_d = hci_pkg::id_t'(k);
        end
      end
    end
  end

  // forward the winning request, id is its channel index
  assign out_req_o  = in_req_i[winner_d];
  assign out_data_o = in_data_i[winner_d];
  assign out_id_o   = winner_d;

  // response payload is broadcast, only r_valid is steered
  assign in_r_o        = out_r_i;
  assign out_r_ready_o = in_r_ready_i[out_r_i.r_id];

  // the held winner keeps its request up until it is granted
  a_out_req_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_req_o && !out_gnt_i |=> out_req_o
  ) else $error("out_req_o dropped without grant");

endmodule

// File: source/hci_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types for the request and response paths of the shared-memory interconnect
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "hci_params.svh"

package hci_pkg;

  // word address, lsb picks the bank
  typedef logic [`HCI_AW-1:0] addr_t;

  // one data word
  typedef logic [`HCI_DW-1:0] data_t;

  // one enable per byte lane
  typedef logic [`HCI_DW/8-1:0] be_t;

  // channel index, used as transaction id
  typedef logic [$clog2(`HCI_NB_CHAN)-1:0] id_t;

  // forced priority per channel, larger wins
  typedef logic [$clog2(`HCI_NB_CHAN)-1:0] prio_t;

  // request payload, valid while req is high
  // wen is high for a read
  typedef struct packed {
    addr_t add;
    logic  wen;
    data_t data;
    be_t   be;
  } hci_req_t;

  // response payload, writes return zero data
  typedef struct packed {
    data_t r_data;
    id_t   r_id;
  } hci_rsp_t;

  // slot of a memory delay lane
  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_BUSY,
    LANE_DONE
  } lane_state_e;

endpackage

// File: source/hci_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and latencies shared by the interconnect mux, the memory model and
// the testbench, pulled in with `include wherever a macro is needed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef HCI_PARAMS_SVH
`define HCI_PARAMS_SVH

// number of initiator channels behind the mux
`define HCI_NB_CHAN 4

// word address and data widths
`define HCI_AW 8
`define HCI_DW 32

// bank 0 answers fast, bank 1 slow
`define HCI_FAST_LAT 1
`define HCI_SLOW_LAT 3

// total words over both banks, must be 2**HCI_AW
`define HCI_DEPTH 256

`endif
